// ==== calc_pkg.sv ====
package calc_pkg;

    // operand entry limits
    localparam int OPERAND_W  = 16;                  // signed operand width
    localparam int RESULT_W   = 32;                  // signed result / display width
    localparam int MAX_DIGITS = 4;                   // decimal digits per operand

    // keypad timing
    localparam int DEBOUNCE_CYCLES = 10;             // consecutive pressed cycles to accept

    // derived counter widths
    localparam int DEB_CNT_W   = $clog2(DEBOUNCE_CYCLES + 1);
    localparam int DIGIT_CNT_W = $clog2(MAX_DIGITS + 1);
    localparam int MUL_CNT_W   = $clog2(OPERAND_W);  // one step per multiplier bit

    // what a decoded key means
    typedef enum logic [2:0] {
        KEY_DIGIT,                                   // 0..9, value in digit field
        KEY_ADD,
        KEY_SUB,
        KEY_MUL,
        KEY_EQUAL,
        KEY_NEG,                                     // sign change of current entry
        KEY_CLEAR,
        KEY_NONE
    } key_kind_t;

    // arithmetic unit opcodes
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_NONE                                      // no pending operator
    } alu_op_t;

    // held key request from scanner to controller
    typedef struct packed {
        key_kind_t  kind;                            // [7:5]
        logic [3:0] digit;                           // [4:1] only meaningful for digits
        logic       valid;                           // [0] held until key_read
    } key_event_t;

endpackage

// ==== keypad_scanner.sv ====
`timescale 1ns/1ps

module keypad_scanner (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           row_in,    // active low rows
    output logic [3:0]           col_out,   // one column driven low
    output calc_pkg::key_event_t key,
    input  logic                 key_read   // one-cycle ack from controller
);
    import calc_pkg::*;

    typedef enum logic [1:0] {
        SCAN,                                   // walk columns
        DEBOUNCE,                               // column frozen, counting
        HOLD,                                   // key reported, waiting for ack
        RELEASE                                 // wait for all rows high
    } scan_state_t;

    scan_state_t          state;
    logic [1:0]           col_idx;              // driven column
    logic [1:0]           row_idx;              // row latched at accept
    logic [DEB_CNT_W-1:0] deb_cnt;              // pressed cycles so far
    logic                 pressed;
    logic [3:0]           key_idx;              // row * 4 + col

    // lowest row reading low
    function automatic logic [1:0] low_row(input logic [3:0] rows);
        logic [1:0] r;
        r = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (!rows[i]) begin
                r = 2'(i);
            end
        end
        return r;
    endfunction

    assign pressed = (row_in != 4'b1111);       // any row pulled low
    assign col_out = ~(4'b0001 << col_idx);     // 1110 after reset
    assign key_idx = {row_idx, col_idx};        // column stays frozen through HOLD

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= SCAN;
            col_idx <= 2'd0;
            row_idx <= 2'd0;
            deb_cnt <= '0;
        end else begin
            case (state)
                SCAN: begin
                    if (pressed) begin
                        state   <= DEBOUNCE;    // freeze column here
                        deb_cnt <= DEB_CNT_W'(1); // first pressed cycle counts
                    end else begin
                        col_idx <= col_idx + 2'd1;
                    end
                end
                DEBOUNCE: begin
                    if (!pressed) begin
                        state   <= SCAN;        // bounce, drop it
                        deb_cnt <= '0;
                    end else if (deb_cnt == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                        state   <= HOLD;        // valid rises with this edge
                        row_idx <= low_row(row_in);
                    end else begin
                        deb_cnt <= deb_cnt + DEB_CNT_W'(1);
                    end
                end
                HOLD: begin
                    if (key_read) begin
                        state <= RELEASE;       // valid drops next edge
                    end
                end
                RELEASE: begin
                    if (!pressed) begin
                        state   <= SCAN;
                        deb_cnt <= '0;
                    end
                end
                default: state <= SCAN;
            endcase
        end
    end

    // key index to kind and digit, only while holding
    always_comb begin
        key.valid = (state == HOLD);
        key.kind  = KEY_NONE;
        key.digit = 4'd0;
        if (state == HOLD) begin
            case (key_idx)
                4'd3:    key.kind = KEY_ADD;
                4'd7:    key.kind = KEY_SUB;
                4'd11:   key.kind = KEY_MUL;
                4'd12:   key.kind = KEY_EQUAL;
                4'd14:   key.kind = KEY_CLEAR;
                4'd15:   key.kind = KEY_NEG;
                default: key.kind = KEY_DIGIT;  // remaining ten keys
            endcase
            case (key_idx)
                4'd0:    key.digit = 4'd1;
                4'd1:    key.digit = 4'd2;
                4'd2:    key.digit = 4'd3;
                4'd4:    key.digit = 4'd4;
                4'd5:    key.digit = 4'd5;
                4'd6:    key.digit = 4'd6;
                4'd8:    key.digit = 4'd7;
                4'd9:    key.digit = 4'd8;
                4'd10:   key.digit = 4'd9;
                default: key.digit = 4'd0;      // 13 is zero, others unused
            endcase
        end
    end

endmodule

// ==== calc_controller.sv ====
`timescale 1ns/1ps

module calc_controller (
    input  logic                                 clk,
    input  logic                                 nRST,
    input  calc_pkg::key_event_t                 key,
    output logic                                 key_read,
    output logic                                 alu_start,
    output calc_pkg::alu_op_t                    alu_op,
    output logic signed [calc_pkg::OPERAND_W-1:0] alu_a,
    output logic signed [calc_pkg::OPERAND_W-1:0] alu_b,
    input  logic                                 alu_done,
    input  logic signed [calc_pkg::RESULT_W-1:0]  alu_result,
    output logic signed [calc_pkg::RESULT_W-1:0]  display_value,
    output logic                                 display_update
);
    import calc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,                                       // ready for a key
        ACK,                                        // key_read high, key consumed
        WAIT_ALU                                    // arithmetic in flight
    } ctrl_state_t;

    ctrl_state_t                 state;
    logic signed [OPERAND_W-1:0] entry;             // operand being typed
    logic signed [OPERAND_W-1:0] entry_next;        // entry with new digit
    logic signed [OPERAND_W-1:0] entry_x10;
    logic signed [OPERAND_W-1:0] digit_val;
    logic signed [OPERAND_W-1:0] acc;               // left operand
    logic [DIGIT_CNT_W-1:0]      digit_cnt;         // digits in entry
    alu_op_t                     pending_op;
    alu_op_t                     key_op;            // operator of current key
    logic                        after_eq;          // last action was a result
    logic signed [RESULT_W-1:0]  last_result;

    assign key_read = (state == ACK);               // one cycle per accepted key
    assign alu_op   = pending_op;
    assign alu_a    = acc;
    assign alu_b    = entry;                        // both stable through WAIT_ALU

    // decimal shift of the entry
    assign digit_val  = OPERAND_W'(key.digit);
    assign entry_x10  = entry * OPERAND_W'(10);
    assign entry_next = entry[OPERAND_W-1] ? entry_x10 - digit_val  // negative grows downward
                                           : entry_x10 + digit_val;

    always_comb begin
        case (key.kind)
            KEY_ADD: key_op = OP_ADD;
            KEY_SUB: key_op = OP_SUB;
            KEY_MUL: key_op = OP_MUL;
            default: key_op = OP_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= IDLE;
            entry          <= '0;
            acc            <= '0;
            digit_cnt      <= '0;
            pending_op     <= OP_NONE;
            after_eq       <= 1'b0;
            last_result    <= '0;
            display_value  <= '0;
            display_update <= 1'b0;
            alu_start      <= 1'b0;
        end else begin
            display_update <= 1'b0;                 // pulses
            alu_start      <= 1'b0;
            case (state)
                IDLE: begin
                    if (key.valid) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    state <= IDLE;
                    case (key.kind)
                        KEY_DIGIT: begin
                            if (digit_cnt < DIGIT_CNT_W'(MAX_DIGITS)) begin
                                entry         <= entry_next;
                                digit_cnt     <= digit_cnt + DIGIT_CNT_W'(1);
                                display_value <= RESULT_W'(entry_next);
                            end else begin
                                display_value <= RESULT_W'(entry); // extra digit dropped
                            end
                            after_eq       <= 1'b0;
                            display_update <= 1'b1;
                        end
                        KEY_NEG: begin
                            entry          <= -entry;
                            display_value  <= -RESULT_W'(entry);
                            display_update <= 1'b1;
                        end
                        KEY_CLEAR: begin
                            entry          <= '0;
                            acc            <= '0;
                            digit_cnt      <= '0;
                            pending_op     <= OP_NONE;
                            after_eq       <= 1'b0;
                            display_value  <= '0;
                            display_update <= 1'b1;
                        end
                        KEY_ADD, KEY_SUB, KEY_MUL: begin
                            // empty entry right after a result chains on it
                            if (after_eq && digit_cnt == '0) begin
                                acc <= last_result[OPERAND_W-1:0];
                            end else begin
                                acc <= entry;
                            end
                            pending_op <= key_op;
                            entry      <= '0;
                            digit_cnt  <= '0;
                            after_eq   <= 1'b0;
                        end
                        KEY_EQUAL: begin
                            if (pending_op != OP_NONE) begin
                                alu_start <= 1'b1;  // acc op entry
                                state     <= WAIT_ALU;
                            end else begin
                                display_value  <= RESULT_W'(entry);
                                display_update <= 1'b1;
                            end
                        end
                        default: ;                  // KEY_NONE just acked
                    endcase
                end
                WAIT_ALU: begin
                    if (alu_done) begin
                        last_result    <= alu_result;
                        display_value  <= alu_result;
                        display_update <= 1'b1;
                        entry          <= '0;
                        digit_cnt      <= '0;
                        pending_op     <= OP_NONE;
                        after_eq       <= 1'b1;
                        state          <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== calc_alu.sv ====
`timescale 1ns/1ps

module calc_alu (
    input  logic                                 clk,
    input  logic                                 nRST,
    input  logic                                 start,
    input  calc_pkg::alu_op_t                    op,
    input  logic signed [calc_pkg::OPERAND_W-1:0] a,
    input  logic signed [calc_pkg::OPERAND_W-1:0] b,
    output logic                                 done,
    output logic signed [calc_pkg::RESULT_W-1:0]  result
);
    import calc_pkg::*;

    typedef enum logic {
        ALU_IDLE,
        ALU_MUL                                     // shift-add loop running
    } alu_state_t;

    alu_state_t                 state;
    logic [MUL_CNT_W-1:0]       iter;               // multiplier bit in use
    logic                       last_iter;
    logic signed [RESULT_W-1:0] a_ext;
    logic signed [RESULT_W-1:0] b_ext;
    logic [OPERAND_W-1:0]       mag_a;              // unsigned magnitudes
    logic [OPERAND_W-1:0]       mag_b;
    logic [RESULT_W-1:0]        mcand;              // shifted left each step
    logic [OPERAND_W-1:0]       mplier;             // shifted right each step
    logic [RESULT_W-1:0]        prod;
    logic [RESULT_W-1:0]        prod_next;
    logic                       neg;                // sign of the product

    assign a_ext     = RESULT_W'(a);                // sign extend
    assign b_ext     = RESULT_W'(b);
    assign mag_a     = a[OPERAND_W-1] ? -a : a;     // -32768 still fits unsigned
    assign mag_b     = b[OPERAND_W-1] ? -b : b;
    assign prod_next = mplier[0] ? prod + mcand : prod;
    assign last_iter = (iter == MUL_CNT_W'(OPERAND_W - 1));

    // control
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ALU_IDLE;
            iter  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ALU_IDLE: begin
                    if (start) begin
                        iter <= '0;
                        if (op == OP_MUL) begin
                            state <= ALU_MUL;
                        end else begin
                            done <= 1'b1;   // add/sub in one cycle
                        end
                    end
                end
                ALU_MUL: begin
                    iter <= iter + MUL_CNT_W'(1);
                    if (last_iter) begin
                        done  <= 1'b1;      // 17 cycles after start
                        state <= ALU_IDLE;
                    end
                end
                default: state <= ALU_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == ALU_IDLE && start) begin
            case (op)
                OP_ADD: result <= a_ext + b_ext;
                OP_SUB: result <= a_ext - b_ext;
                OP_MUL: begin
                    mcand  <= RESULT_W'(mag_a);
                    mplier <= mag_b;
                    prod   <= '0;
                    neg    <= a[OPERAND_W-1] ^ b[OPERAND_W-1];
                end
                default: result <= '0;
            endcase
        end else if (state == ALU_MUL) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            prod   <= prod_next;
            if (last_iter) begin
                result <= neg ? -signed'(prod_next) : signed'(prod_next); // sign applied last
            end
        end
    end

endmodule

// ==== calc_top.sv ====
`timescale 1ns/1ps

module calc_top (
    input  logic                                clk,
    input  logic                                nRST,
    input  logic [3:0]                          row_in,
    output logic [3:0]                          col_out,
    output logic signed [calc_pkg::RESULT_W-1:0] display_value,
    output logic                                display_update
);
    import calc_pkg::*;

    key_event_t                  key;           // held key request
    logic                        key_read;
    logic                        alu_start;
    alu_op_t                     alu_op;
    logic signed [OPERAND_W-1:0] alu_a;
    logic signed [OPERAND_W-1:0] alu_b;
    logic                        alu_done;
    logic signed [RESULT_W-1:0]  alu_result;

    keypad_scanner u_scanner (
        .clk      (clk),
        .nRST     (nRST),
        .row_in   (row_in),
        .col_out  (col_out),
        .key      (key),
        .key_read (key_read)
    );

    calc_controller u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .key            (key),
        .key_read       (key_read),
        .alu_start      (alu_start),
        .alu_op         (alu_op),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .alu_done       (alu_done),
        .alu_result     (alu_result),
        .display_value  (display_value),
        .display_update (display_update)
    );

    calc_alu u_alu (
        .clk    (clk),
        .nRST   (nRST),
        .start  (alu_start),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .done   (alu_done),
        .result (alu_result)
    );

endmodule

// ==== tb_calc_top.sv ====
`timescale 1ns/1ps

module tb_calc_top;
    import calc_pkg::*;

    localparam int IDX_ADD       = 3;               // keypad map index is row * 4 + col
    localparam int IDX_SUB       = 7;
    localparam int IDX_MUL       = 11;
    localparam int IDX_EQUAL     = 12;
    localparam int IDX_CLEAR     = 14;
    localparam int IDX_NEG       = 15;
    localparam int HOLD_CYCLES   = 30;              // full press
    localparam int GAP_CYCLES    = 5;               // idle after release
    localparam int DRAIN_TIMEOUT = 200;             // cycles to wait for an update

    logic                       clk;
    logic                       nRST;
    logic [3:0]                 row_in;
    logic [3:0]                 col_out;
    logic signed [RESULT_W-1:0] display_value;
    logic                       display_update;

    logic        key_down;                          // keypad model state
    logic [1:0]  press_row;
    logic [1:0]  press_col;
    logic [15:0] lfsr_state = 16'd7726;
    string       test_name;
    int          exp_q[$];                          // expected display values in order
    int          exp_val;
    int          updates_seen = 0;

    calc_top DUT (
        .clk            (clk),
        .nRST           (nRST),
        .row_in         (row_in),
        .col_out        (col_out),
        .display_value  (display_value),
        .display_update (display_update)
    );

    always #50 clk = ~clk;                          // 100 ns period

    // row pulled low only while its column is driven
    assign row_in = (key_down && !col_out[press_col]) ? ~(4'b0001 << press_row) : 4'b1111;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input int expected, input int actual);
        assert (actual == expected)
            else fail_run($sformatf("** Error: %s expected %0d actual %0d",
                                    test_name, expected, actual));
    endtask

    col_one_cold: assert property (@(posedge clk) disable iff (!nRST) $onehot(~col_out))
        else fail_run("col_out does not drive exactly one column low");
    update_pulse: assert property (@(posedge clk) disable iff (!nRST)
                                   display_update |=> !display_update)
        else fail_run("display_update stayed high for more than one cycle");

    // every update must match the next expected value
    always @(posedge clk) begin
        if (nRST && display_update) begin
            updates_seen++;
            if (exp_q.size() == 0) begin
                fail_run($sformatf("display update with no key expecting one in test %s",
                                   test_name));
            end else begin
                exp_val = exp_q.pop_front();
                check_value(exp_val, display_value);
            end
        end
    end

    // galois lfsr stepped once per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic int rand_digit();
        int v;
        v = 0;
        for (int i = 0; i < 4; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v % 10;
    endfunction

    // tens digit drawn before units digit
    function automatic int rand_operand();
        int tens;
        tens = rand_digit();
        return tens * 10 + rand_digit();
    endfunction

    // digits 1..9 fill rows 0..2 and cols 0..2 while zero is key 13
    function automatic int digit_key(input int d);
        if (d == 0) begin
            return 13;
        end
        return ((d - 1) / 3) * 4 + (d - 1) % 3;
    endfunction

    task automatic press_key(input int idx, input int hold);
        @(posedge clk);
        #10;
        press_row = 2'(idx / 4);
        press_col = 2'(idx % 4);
        key_down  = 1'b1;
        repeat (hold) @(posedge clk);
        #10;
        key_down = 1'b0;
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_run($sformatf("timeout waiting for display update in test %s",
                                   test_name));
            end
        end
    endtask

    task automatic press_expect(input int idx, input int value);
        exp_q.push_back(value);
        press_key(idx, HOLD_CYCLES);
        wait_drain();
    endtask

    // non-negative value of up to four digits entered msb first
    task automatic enter_number(input int value);
        int digits[4];
        int n;
        int v;
        int partial;
        n = 0;
        v = value;
        partial = 0;
        do begin
            digits[n] = v % 10;
            v = v / 10;
            n++;
        end while (v != 0);
        for (int i = n - 1; i >= 0; i--) begin
            partial = partial * 10 + digits[i];
            press_expect(digit_key(digits[i]), partial);
        end
    endtask

    task automatic run_binop(input int a, input int op_idx, input int b, input int result);
        press_expect(IDX_CLEAR, 0);                 // start from a clean state
        enter_number(a);
        press_key(op_idx, HOLD_CYCLES);             // operator key gives no update
        enter_number(b);
        press_expect(IDX_EQUAL, result);
    endtask

    initial begin
        int         a;
        int         b;
        int         seen;
        logic [3:0] cols_seen;
        clk       = 1'b0;
        nRST      = 1'b0;
        key_down  = 1'b0;
        press_row = 2'd0;
        press_col = 2'd0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        check_value(0, display_value);
        check_value(0, int'(display_update));
        check_value(14, int'(col_out));             // 1110
        #10;
        nRST = 1'b1;

        test_name = "scan";
        cols_seen = 4'b0000;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            cols_seen = cols_seen | ~col_out;       // collect driven columns
        end
        check_value(15, int'(cols_seen));

        test_name = "digits";
        enter_number(1234);                         // 1, 12, 123, 1234
        press_expect(digit_key(5), 1234);           // fifth digit dropped

        for (int i = 0; i < 3; i++) begin
            test_name = "add";
            a = rand_operand();
            b = rand_operand();
            run_binop(a, IDX_ADD, b, a + b);
            test_name = "sub";
            a = rand_operand();
            b = rand_operand();
            run_binop(a, IDX_SUB, b, a - b);
        end

        test_name = "mul_max";
        run_binop(9999, IDX_MUL, 9999, 99980001);
        test_name = "mul_rand";
        a = rand_operand();
        b = rand_operand();
        run_binop(a, IDX_MUL, b, a * b);

        test_name = "negate";
        press_expect(IDX_CLEAR, 0);
        enter_number(7);
        press_expect(IDX_NEG, -7);
        test_name = "clear";
        press_expect(IDX_CLEAR, 0);
        test_name = "chain";
        run_binop(5, IDX_MUL, 3, 15);
        press_key(IDX_ADD, HOLD_CYCLES);            // result becomes left operand
        enter_number(4);
        press_expect(IDX_EQUAL, 19);

        test_name = "debounce";
        press_expect(IDX_CLEAR, 0);
        seen = updates_seen;
        press_key(digit_key(8), DEBOUNCE_CYCLES - 1); // one cycle short of acceptance
        repeat (100) @(posedge clk);
        check_value(seen, updates_seen);
        enter_number(8);                            // full press still works

        $display("Test passed");
        $finish;
    end

endmodule

// ==== calc_top.f ====
calc_pkg.sv
keypad_scanner.sv
calc_controller.sv
calc_alu.sv
calc_top.sv
tb_calc_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_calc_top -f calc_top.f -o sim_calc
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed"
    exit "$status"
fi

./obj_dir/sim_calc
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi
exit "$status"
